// File: common/fpu_cfg.svh
`ifndef FPU_CFG_SVH
`define FPU_CFG_SVH

// Stored binary32 layout.
`define FPU_EXP_BITS 8
`define FPU_FRAC_BITS 23
`define FPU_BIAS 127

// Unpacked operand widths.
// The exponent is signed and unbiased, and the significand holds the
// fraction bits below an implied leading one.
`define FPU_IN_EXP_WIDTH 9
`define FPU_IN_SIG_WIDTH 23

// Unrounded sum widths.
// The significand is 23 fraction bits, a round bit and a sticky bit.
`define FPU_OUT_EXP_WIDTH 10
`define FPU_OUT_SIG_WIDTH 25

`endif

// File: common/fpu_format_pkg.sv
`include "fpu_cfg.svh"

package fpu_format_pkg;

  // Field view of a stored binary32 word.
  typedef struct packed {
    logic                      sign;
    logic [`FPU_EXP_BITS-1:0]  exponent;
    logic [`FPU_FRAC_BITS-1:0] fraction;
  } float32_fields_t;

  // The same word is moved around whole and decoded by fields.
  typedef union packed {
    logic [`FPU_EXP_BITS+`FPU_FRAC_BITS:0] raw;
    float32_fields_t                       fields;
  } float32_u;

  // Quiet NaN with a positive sign and only the top fraction bit set.
  localparam logic [31:0] CANONICAL_NAN = 32'h7fc00000;

endpackage

// File: common/fpu_op_pkg.sv
`include "fpu_cfg.svh"

package fpu_op_pkg;

  // Encoded the same way as the RISC-V frm field.
  typedef enum logic [2:0] {
    RoundTiesToEven     = 3'b000,
    RoundTowardZero     = 3'b001,
    RoundTowardNegative = 3'b010,
    RoundTowardPositive = 3'b011,
    RoundTiesToAway     = 3'b100
  } rounding_mode_e;

  // One decoded operand.
  // The significand has the leading one removed, also for subnormal inputs.
  typedef struct packed {
    logic                                sign;
    logic signed [`FPU_IN_EXP_WIDTH-1:0] exponent;
    logic [`FPU_IN_SIG_WIDTH-1:0]        significand;
    logic                                is_zero;
    logic                                is_inf;
    logic                                is_nan;
  } operand_t;

  // Unrounded result of the adder core.
  typedef struct packed {
    logic                                 invalid_operation;
    logic                                 sign;
    logic signed [`FPU_OUT_EXP_WIDTH-1:0] exponent;
    logic [`FPU_OUT_SIG_WIDTH-1:0]        significand;
    logic                                 is_zero;
    logic                                 is_inf;
    logic                                 is_nan;
  } sum_t;

  typedef struct packed {
    logic invalid;
    logic overflow;
    logic underflow;
    logic inexact;
  } fflags_t;

endpackage

// File: rtl/fpu_normalize.sv
`timescale 1ns/10ps

module fpu_normalize #(
  parameter int DataWidth = 26
) (
  input  logic [DataWidth-1:0]         data_i,
  output logic                         is_zero_o,
  output logic [$clog2(DataWidth)-1:0] shift_o,
  output logic [DataWidth-1:0]         data_o
);

  localparam int ShiftWidth = $clog2(DataWidth);

  assign is_zero_o = ~|data_i;

  // Leading-zero count.
  // Scanning upwards lets the highest set bit win, so the last match is the answer.
  always_comb begin
    shift_o = '0;
    for (int i = 0; i < DataWidth; i++) begin
      if (data_i[i]) begin
        shift_o = ShiftWidth'(DataWidth - 1 - i);
      end
    end
  end

  // An all-zero input has a count of zero and passes through unchanged.
  assign data_o = data_i << shift_o;

endmodule

// File: rtl/fpu_unpack.sv
`timescale 1ns/10ps
`include "fpu_cfg.svh"

module fpu_unpack (
  input  fpu_format_pkg::float32_u in_i,
  output fpu_op_pkg::operand_t     operand_o
);

  localparam int FracWidth  = `FPU_FRAC_BITS;
  localparam int ShiftWidth = $clog2(FracWidth);
  localparam int ExpWidth   = `FPU_IN_EXP_WIDTH;

  logic [`FPU_EXP_BITS-1:0] exp_field;
  logic [FracWidth-1:0]     frac_field;
  logic [FracWidth-1:0]     frac_norm;
  logic [ShiftWidth-1:0]    frac_shift;
  logic                     exp_is_min;
  logic                     exp_is_max;
  logic                     frac_is_zero;

  assign exp_field  = in_i.fields.exponent;
  assign frac_field = in_i.fields.fraction;
  assign exp_is_min = exp_field == '0;
  assign exp_is_max = &exp_field;

  fpu_normalize #(
    .DataWidth (FracWidth)
  ) u_normalize (
    .data_i    (frac_field),
    .is_zero_o (frac_is_zero),
    .shift_o   (frac_shift),
    .data_o    (frac_norm)
  );

  always_comb begin
    operand_o.sign    = in_i.fields.sign;
    operand_o.is_zero = exp_is_min && frac_is_zero;
    operand_o.is_inf  = exp_is_max && frac_is_zero;
    operand_o.is_nan  = exp_is_max && !frac_is_zero;

    if (exp_is_min) begin
      // Subnormal.
      // After the shift the leading one sits at the top and is dropped with one
      // more shift, so the value is 1.f times 2 to the power of -127 minus the count.
      operand_o.exponent    = -ExpWidth'(`FPU_BIAS) - ExpWidth'(frac_shift);
      operand_o.significand = frac_norm << 1;
    end else begin
      // Normal, infinity and NaN keep the fraction, so a NaN keeps its quiet bit.
      operand_o.exponent    = ExpWidth'(exp_field) - ExpWidth'(`FPU_BIAS);
      operand_o.significand = frac_field;
    end
  end

endmodule

// File: fpu_add/fpu_right_shift.sv
`timescale 1ns/10ps

module fpu_right_shift #(
  parameter int DataWidth  = 27,
  parameter int ShiftWidth = 9
) (
  input  logic [DataWidth-1:0]  data_i,
  input  logic [ShiftWidth-1:0] shift_i,
  output logic [DataWidth-1:0]  data_o
);

  logic lost;

  // Every bit below the shift amount falls off the end.
  always_comb begin
    lost = 1'b0;
    for (int i = 0; i < DataWidth; i++) begin
      if (ShiftWidth'(i) < shift_i) begin
        lost = lost | data_i[i];
      end
    end
  end

  // An oversized shift clears the data, and the sticky bit then holds any nonzero input.
  assign data_o = (data_i >> shift_i) | {{(DataWidth-1){1'b0}}, lost};

endmodule

// File: fpu_add/fpu_add.sv
`timescale 1ns/10ps
`include "fpu_cfg.svh"

module fpu_add (
  input  fpu_op_pkg::rounding_mode_e rounding_mode_i,
  input  fpu_op_pkg::operand_t       a_i,
  input  fpu_op_pkg::operand_t       b_i,
  output fpu_op_pkg::sum_t           sum_o
);

  localparam int SigWidth       = `FPU_IN_SIG_WIDTH;
  localparam int ExpWidth       = `FPU_OUT_EXP_WIDTH;
  // Hidden one, fraction and three low bits for guard, round and sticky.
  localparam int ExtWidth       = SigWidth + 4;
  localparam int NormWidth      = ExtWidth - 1;
  localparam int NormShiftWidth = $clog2(NormWidth);

  logic                       subtract_mag;
  logic                       cancel_sign;
  logic                       a_is_snan;
  logic                       b_is_snan;
  logic                       both_zero;
  logic                       result_nan;
  logic                       result_inf;
  logic                       special;
  logic                       special_sign;
  logic signed [ExpWidth-1:0] a_exp;
  logic signed [ExpWidth-1:0] b_exp;
  logic signed [ExpWidth-1:0] exp_diff;
  logic signed [ExpWidth-1:0] neg_exp_diff;
  logic signed [ExpWidth-1:0] big_exp;
  logic                       swap;
  logic [ExtWidth-1:0]        a_ext;
  logic [ExtWidth-1:0]        b_ext;
  logic [ExtWidth-1:0]        a_shifted;
  logic [ExtWidth-1:0]        b_shifted;
  logic [ExtWidth-1:0]        big_sig;
  logic [ExtWidth-1:0]        small_sig;
  logic [ExtWidth:0]          mag_sum;
  logic                       carry;
  logic [NormWidth-1:0]       norm_in;
  logic [NormWidth-1:0]       norm_sig;
  logic                       norm_extra_sticky;
  logic                       norm_zero;
  logic [NormShiftWidth-1:0]  norm_shift;

  assign subtract_mag = a_i.sign ^ b_i.sign;
  assign cancel_sign  = rounding_mode_i == fpu_op_pkg::RoundTowardNegative;

  // A NaN with a clear top fraction bit is signaling.
  assign a_is_snan = a_i.is_nan && !a_i.significand[SigWidth-1];
  assign b_is_snan = b_i.is_nan && !b_i.significand[SigWidth-1];

  assign both_zero    = a_i.is_zero && b_i.is_zero;
  assign result_nan   = a_i.is_nan || b_i.is_nan || (a_i.is_inf && b_i.is_inf && subtract_mag);
  assign result_inf   = !result_nan && (a_i.is_inf || b_i.is_inf);
  assign special      = result_nan || result_inf || both_zero;
  assign special_sign = a_i.is_inf ? a_i.sign :
                        b_i.is_inf ? b_i.sign :
                        both_zero  ? (subtract_mag ? cancel_sign : a_i.sign) : 1'b0;

  // The larger magnitude goes first, so the difference is never negative.
  assign a_exp        = $signed(a_i.exponent);
  assign b_exp        = $signed(b_i.exponent);
  assign exp_diff     = a_exp - b_exp;
  assign neg_exp_diff = -exp_diff;
  assign swap = (exp_diff < 0) || (exp_diff == 0 && a_i.significand < b_i.significand);

  assign a_ext = {1'b1, a_i.significand, 3'b000};
  assign b_ext = {1'b1, b_i.significand, 3'b000};

  // Only the shifter on the smaller operand is selected below.
  fpu_right_shift #(
    .DataWidth  (ExtWidth),
    .ShiftWidth (`FPU_IN_EXP_WIDTH)
  ) u_shift_a (
    .data_i  (a_ext),
    .shift_i (neg_exp_diff[`FPU_IN_EXP_WIDTH-1:0]),
    .data_o  (a_shifted)
  );

  fpu_right_shift #(
    .DataWidth  (ExtWidth),
    .ShiftWidth (`FPU_IN_EXP_WIDTH)
  ) u_shift_b (
    .data_i  (b_ext),
    .shift_i (exp_diff[`FPU_IN_EXP_WIDTH-1:0]),
    .data_o  (b_shifted)
  );

  assign big_exp   = swap ? b_exp : a_exp;
  assign big_sig   = swap ? b_ext : a_ext;
  assign small_sig = swap ? a_shifted : b_shifted;
  assign mag_sum   = subtract_mag ? (ExtWidth+1)'(big_sig) - (ExtWidth+1)'(small_sig) :
                                    (ExtWidth+1)'(big_sig) + (ExtWidth+1)'(small_sig);

  // A carry can only come from an addition, which never needs a left shift.
  // The lowest bit drops out of the normalizer and rejoins as sticky.
  assign carry             = mag_sum[ExtWidth];
  assign norm_in           = carry ? mag_sum[ExtWidth:2] : mag_sum[ExtWidth-1:1];
  assign norm_extra_sticky = carry ? |mag_sum[1:0] : mag_sum[0];

  fpu_normalize #(
    .DataWidth (NormWidth)
  ) u_normalize (
    .data_i    (norm_in),
    .is_zero_o (norm_zero),
    .shift_o   (norm_shift),
    .data_o    (norm_sig)
  );

  always_comb begin
    sum_o.invalid_operation = a_is_snan || b_is_snan ||
                              (a_i.is_inf && b_i.is_inf && subtract_mag);
    sum_o.is_nan  = result_nan;
    sum_o.is_inf  = result_inf;
    sum_o.is_zero = both_zero ||
                    (!special && !a_i.is_zero && !b_i.is_zero && norm_zero);

    if (a_i.is_zero) begin
      sum_o.sign        = b_i.sign;
      sum_o.exponent    = b_exp;
      sum_o.significand = {b_i.significand, 2'b00};
    end else if (b_i.is_zero) begin
      sum_o.sign        = a_i.sign;
      sum_o.exponent    = a_exp;
      sum_o.significand = {a_i.significand, 2'b00};
    end else begin
      sum_o.sign        = norm_zero ? cancel_sign : (swap ? b_i.sign : a_i.sign);
      sum_o.exponent    = big_exp + ExpWidth'(carry) - ExpWidth'(norm_shift);
      sum_o.significand = {norm_sig[NormWidth-2:1], norm_sig[0] | norm_extra_sticky};
    end

    if (special) begin
      sum_o.sign = special_sign;
    end
  end

endmodule

// File: rtl/fpu_round_pack.sv
`timescale 1ns/10ps
`include "fpu_cfg.svh"

module fpu_round_pack (
  input  fpu_op_pkg::rounding_mode_e rounding_mode_i,
  input  fpu_op_pkg::sum_t           sum_i,
  output fpu_format_pkg::float32_u   result_o,
  output fpu_op_pkg::fflags_t        fflags_o
);

  localparam int ExpWidth  = `FPU_OUT_EXP_WIDTH;
  localparam int FracWidth = `FPU_FRAC_BITS;
  localparam int MantWidth = `FPU_OUT_SIG_WIDTH + 1;
  localparam int WordWidth = `FPU_EXP_BITS + FracWidth;
  localparam logic [`FPU_EXP_BITS-1:0] ExpMax = '1;

  logic signed [ExpWidth-1:0] biased_exp;
  logic [ExpWidth-1:0]        denorm_shift;
  logic [MantWidth-1:0]       mant;
  logic [MantWidth-1:0]       denorm_mant;
  logic                       denorm_lost;
  logic                       tiny;
  logic                       pre_overflow;
  logic [FracWidth-1:0]       frac_kept;
  logic                       round_bit;
  logic                       sticky_bit;
  logic                       lsb;
  logic                       round_up;
  logic [WordWidth-1:0]       unrounded;
  logic [WordWidth-1:0]       rounded;
  logic                       overflow;
  logic                       max_finite;

  assign biased_exp   = $signed(sum_i.exponent) + ExpWidth'(`FPU_BIAS);
  assign tiny         = biased_exp <= 0;
  assign pre_overflow = biased_exp >= 255;

  // Mantissa with the leading one restored, above the round and sticky bits.
  assign mant = {1'b1, sum_i.significand};

  // Results below the normal range are shifted down to the subnormal position.
  assign denorm_shift = ExpWidth'(1) - biased_exp;
  assign denorm_lost  = |(mant & ~({MantWidth{1'b1}} << denorm_shift));
  assign denorm_mant  = (mant >> denorm_shift) | {{(MantWidth-1){1'b0}}, denorm_lost};

  assign frac_kept  = tiny ? denorm_mant[MantWidth-2:2] : mant[MantWidth-2:2];
  assign round_bit  = tiny ? denorm_mant[1] : mant[1];
  assign sticky_bit = tiny ? denorm_mant[0] : mant[0];
  assign lsb        = frac_kept[0];

  always_comb begin
    case (rounding_mode_i)
      fpu_op_pkg::RoundTiesToEven:     round_up = round_bit && (sticky_bit || lsb);
      fpu_op_pkg::RoundTowardZero:     round_up = 1'b0;
      fpu_op_pkg::RoundTowardNegative: round_up = sum_i.sign && (round_bit || sticky_bit);
      fpu_op_pkg::RoundTowardPositive: round_up = !sum_i.sign && (round_bit || sticky_bit);
      fpu_op_pkg::RoundTiesToAway:     round_up = round_bit;
      default:                         round_up = 1'b0;
    endcase
  end

  // A fraction carry runs into the exponent field, which also covers
  // a subnormal rounding up to the smallest normal.
  assign unrounded = {tiny ? '0 : biased_exp[`FPU_EXP_BITS-1:0], frac_kept};
  assign rounded   = unrounded + WordWidth'(round_up);
  assign overflow  = pre_overflow || (rounded[WordWidth-1:FracWidth] == ExpMax);

  // Directed rounding away from the result's sign stops at the largest finite value.
  assign max_finite = (rounding_mode_i == fpu_op_pkg::RoundTowardZero) ||
                      (rounding_mode_i == fpu_op_pkg::RoundTowardNegative && !sum_i.sign) ||
                      (rounding_mode_i == fpu_op_pkg::RoundTowardPositive && sum_i.sign);

  always_comb begin
    fflags_o             = '0;
    result_o.raw         = '0;
    result_o.fields.sign = sum_i.sign;

    if (sum_i.is_nan) begin
      result_o.raw     = fpu_format_pkg::CANONICAL_NAN;
      fflags_o.invalid = sum_i.invalid_operation;
    end else if (sum_i.is_inf) begin
      result_o.fields.exponent = ExpMax;
    end else if (!sum_i.is_zero) begin
      if (overflow) begin
        result_o.fields.exponent = max_finite ? ExpMax - 1'b1 : ExpMax;
        result_o.fields.fraction = max_finite ? '1 : '0;
        fflags_o.overflow        = 1'b1;
        fflags_o.inexact         = 1'b1;
      end else begin
        {result_o.fields.exponent, result_o.fields.fraction} = rounded;
        fflags_o.inexact   = round_bit || sticky_bit;
        // Tininess is judged before rounding.
        fflags_o.underflow = tiny && (round_bit || sticky_bit);
      end
    end
  end

endmodule

// File: rtl/fpu_add_top.sv
`timescale 1ns/10ps

module fpu_add_top (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  logic                       req_valid_i,
  input  fpu_op_pkg::rounding_mode_e rounding_mode_i,
  input  fpu_format_pkg::float32_u   a_i,
  input  fpu_format_pkg::float32_u   b_i,
  output logic                       resp_valid_o,
  output fpu_format_pkg::float32_u   result_o,
  output fpu_op_pkg::fflags_t        fflags_o
);

  fpu_op_pkg::operand_t     a_op;
  fpu_op_pkg::operand_t     b_op;
  fpu_op_pkg::sum_t         sum;
  fpu_format_pkg::float32_u result_d;
  fpu_op_pkg::fflags_t      fflags_d;

  fpu_unpack u_unpack_a (
    .in_i      (a_i),
    .operand_o (a_op)
  );

  fpu_unpack u_unpack_b (
    .in_i      (b_i),
    .operand_o (b_op)
  );

  fpu_add u_add (
    .rounding_mode_i (rounding_mode_i),
    .a_i             (a_op),
    .b_i             (b_op),
    .sum_o           (sum)
  );

  fpu_round_pack u_round_pack (
    .rounding_mode_i (rounding_mode_i),
    .sum_i           (sum),
    .result_o        (result_d),
    .fflags_o        (fflags_d)
  );

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      resp_valid_o <= 1'b0;
    end else begin
      resp_valid_o <= req_valid_i;
    end
  end

  // The result holds between requests.
  always_ff @(posedge clk_i) begin
    if (req_valid_i) begin
      result_o <= result_d;
      fflags_o <= fflags_d;
    end
  end

endmodule

// File: tb/fpu_add_vectors.svh
`ifndef FPU_ADD_VECTORS_SVH
`define FPU_ADD_VECTORS_SVH

// Columns are operand a, operand b, rounding mode, expected result word and
// expected flags as {invalid, overflow, underflow, inexact}.
localparam int num_vectors = 39;

localparam vector_t vectors [num_vectors] = '{
  // Exact sums and cancellations.
  '{32'h3f800000, 32'h40000000, fpu_op_pkg::RoundTiesToEven,     32'h40400000, 4'h0},
  '{32'h3fc00000, 32'h40200000, fpu_op_pkg::RoundTiesToEven,     32'h40800000, 4'h0},
  '{32'hbf800000, 32'h3f000000, fpu_op_pkg::RoundTiesToEven,     32'hbf000000, 4'h0},
  '{32'h3f800000, 32'hbf800000, fpu_op_pkg::RoundTiesToEven,     32'h00000000, 4'h0},
  '{32'h3f800000, 32'hbf800000, fpu_op_pkg::RoundTowardNegative, 32'h80000000, 4'h0},
  '{32'h80000000, 32'h80000000, fpu_op_pkg::RoundTiesToEven,     32'h80000000, 4'h0},
  '{32'h00000000, 32'h80000000, fpu_op_pkg::RoundTowardNegative, 32'h80000000, 4'h0},
  // 1 plus 2^-24 is a tie with an even last bit.
  '{32'h3f800000, 32'h33800000, fpu_op_pkg::RoundTiesToEven,     32'h3f800000, 4'h1},
  '{32'h3f800000, 32'h33800000, fpu_op_pkg::RoundTowardZero,     32'h3f800000, 4'h1},
  '{32'h3f800000, 32'h33800000, fpu_op_pkg::RoundTowardNegative, 32'h3f800000, 4'h1},
  '{32'h3f800000, 32'h33800000, fpu_op_pkg::RoundTowardPositive, 32'h3f800001, 4'h1},
  '{32'h3f800000, 32'h33800000, fpu_op_pkg::RoundTiesToAway,     32'h3f800001, 4'h1},
  // A tie with an odd last bit.
  '{32'h3f800001, 32'h33800000, fpu_op_pkg::RoundTiesToEven,     32'h3f800002, 4'h1},
  '{32'h3f800001, 32'h33800000, fpu_op_pkg::RoundTowardZero,     32'h3f800001, 4'h1},
  '{32'h3f800001, 32'h33800000, fpu_op_pkg::RoundTiesToAway,     32'h3f800002, 4'h1},
  // Negative tie.
  '{32'hbf800000, 32'hb3800000, fpu_op_pkg::RoundTiesToEven,     32'hbf800000, 4'h1},
  '{32'hbf800000, 32'hb3800000, fpu_op_pkg::RoundTowardNegative, 32'hbf800001, 4'h1},
  '{32'hbf800000, 32'hb3800000, fpu_op_pkg::RoundTowardPositive, 32'hbf800000, 4'h1},
  '{32'hbf800000, 32'hb3800000, fpu_op_pkg::RoundTiesToAway,     32'hbf800001, 4'h1},
  // Above the halfway point.
  '{32'h3f800000, 32'h33c00000, fpu_op_pkg::RoundTiesToEven,     32'h3f800001, 4'h1},
  '{32'h3f800000, 32'h33c00000, fpu_op_pkg::RoundTowardZero,     32'h3f800000, 4'h1},
  // Subnormal inputs and outputs. Tiny sums are always exact.
  '{32'h00000001, 32'h00000001, fpu_op_pkg::RoundTiesToEven,     32'h00000002, 4'h0},
  '{32'h00800000, 32'h80000001, fpu_op_pkg::RoundTiesToEven,     32'h007fffff, 4'h0},
  '{32'h3f800000, 32'h00000001, fpu_op_pkg::RoundTiesToEven,     32'h3f800000, 4'h1},
  '{32'h3f800000, 32'h00000001, fpu_op_pkg::RoundTowardPositive, 32'h3f800001, 4'h1},
  '{32'h007fffff, 32'h00000001, fpu_op_pkg::RoundTiesToEven,     32'h00800000, 4'h0},
  // Overflow goes to infinity or the largest finite value by mode and sign.
  '{32'h7f7fffff, 32'h7f7fffff, fpu_op_pkg::RoundTiesToEven,     32'h7f800000, 4'h5},
  '{32'h7f7fffff, 32'h7f7fffff, fpu_op_pkg::RoundTowardZero,     32'h7f7fffff, 4'h5},
  '{32'h7f7fffff, 32'h7f7fffff, fpu_op_pkg::RoundTowardNegative, 32'h7f7fffff, 4'h5},
  '{32'h7f7fffff, 32'h7f7fffff, fpu_op_pkg::RoundTowardPositive, 32'h7f800000, 4'h5},
  '{32'hff7fffff, 32'hff7fffff, fpu_op_pkg::RoundTowardNegative, 32'hff800000, 4'h5},
  '{32'hff7fffff, 32'hff7fffff, fpu_op_pkg::RoundTowardPositive, 32'hff7fffff, 4'h5},
  '{32'h7f7fffff, 32'h73000000, fpu_op_pkg::RoundTiesToEven,     32'h7f800000, 4'h5},
  '{32'h7f7fffff, 32'h73000000, fpu_op_pkg::RoundTowardZero,     32'h7f7fffff, 4'h1},
  // Infinities and NaNs.
  '{32'h7f800000, 32'h7f800000, fpu_op_pkg::RoundTiesToEven,     32'h7f800000, 4'h0},
  '{32'hff800000, 32'h3f800000, fpu_op_pkg::RoundTiesToEven,     32'hff800000, 4'h0},
  '{32'h7f800000, 32'hff800000, fpu_op_pkg::RoundTiesToEven,     32'h7fc00000, 4'h8},
  '{32'h7f800001, 32'h3f800000, fpu_op_pkg::RoundTiesToEven,     32'h7fc00000, 4'h8},
  '{32'hffc12345, 32'h3f800000, fpu_op_pkg::RoundTiesToEven,     32'h7fc00000, 4'h0}
};

`endif

// File: tb/tb_fpu_add.sv
`timescale 1ns/10ps

module tb_fpu_add;

  localparam int timeout_cycles = 20;

  typedef struct packed {
    logic [31:0]                a;
    logic [31:0]                b;
    fpu_op_pkg::rounding_mode_e mode;
    logic [31:0]                result;
    fpu_op_pkg::fflags_t        flags;
  } vector_t;

`include "fpu_add_vectors.svh"

  logic                       clk;
  logic                       rst_n;
  logic                       req_valid;
  fpu_op_pkg::rounding_mode_e rounding_mode;
  fpu_format_pkg::float32_u   op_a;
  fpu_format_pkg::float32_u   op_b;
  logic                       resp_valid;
  fpu_format_pkg::float32_u   result;
  fpu_op_pkg::fflags_t        fflags;
  int                         seed;
  int                         tests;
  int                         checks;
  int                         errors;

  fpu_add_top UUT (
    .clk_i           (clk),
    .rst_n_i         (rst_n),
    .req_valid_i     (req_valid),
    .rounding_mode_i (rounding_mode),
    .a_i             (op_a),
    .b_i             (op_b),
    .resp_valid_o    (resp_valid),
    .result_o        (result),
    .fflags_o        (fflags)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic compare_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
    checks++;
    assert (actual == expected) else begin
      $display("error: %s expected %h got %h", name, expected, actual);
      errors++;
    end
  endtask

  task automatic report_test(input string name, input int first_error);
    tests++;
    $display("%s: %0d errors", name, errors - first_error);
  endtask

  function automatic fpu_op_pkg::rounding_mode_e mode_of(input int m);
    return fpu_op_pkg::rounding_mode_e'(3'(m));
  endfunction

  // Clears an all-ones exponent and avoids zero, which leaves a finite nonzero word.
  function automatic logic [31:0] make_finite(input logic [31:0] word);
    logic [31:0] w;
    w = word;
    if (w[30:23] == 8'hff) begin
      w[30] = 1'b0;
    end
    if (w[30:0] == 31'd0) begin
      w[0] = 1'b1;
    end
    return w;
  endfunction

  // Issues one request on a falling edge and waits for its response.
  task automatic run_op(input logic [31:0] a_word, input logic [31:0] b_word,
                        input fpu_op_pkg::rounding_mode_e mode,
                        output logic [31:0] res_word, output logic [31:0] flag_word);
    int waited;
    @(negedge clk);
    op_a.raw      = a_word;
    op_b.raw      = b_word;
    rounding_mode = mode;
    req_valid     = 1'b1;
    waited        = 0;
    do begin
      @(negedge clk);
      req_valid = 1'b0;
      waited++;
    end while (!resp_valid && waited < timeout_cycles);
    if (!resp_valid) begin
      $display("Timeout: resp_valid_o did not rise within %0d cycles", timeout_cycles);
      $display("Test failed");
      $finish;
    end else begin
      res_word  = result.raw;
      flag_word = 32'(fflags);
    end
  endtask

  initial begin
    logic [31:0] res1;
    logic [31:0] res2;
    logic [31:0] flg1;
    logic [31:0] flg2;
    logic [31:0] x;
    logic [31:0] y;
    logic [9:0]  burst;
    logic        prev_valid;
    int          prev_idx;
    int          next_idx;
    int          test_start;

    seed          = 32'h6e8acbe0;
    tests         = 0;
    checks        = 0;
    errors        = 0;
    rst_n         = 1'b0;
    req_valid     = 1'b0;
    op_a          = '0;
    op_b          = '0;
    rounding_mode = fpu_op_pkg::RoundTiesToEven;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // Each response must follow its request by exactly one cycle.
    test_start = errors;
    compare_value("resp_valid_o", 32'd0, 32'(resp_valid));
    burst      = 10'b1101001110;
    prev_valid = 1'b0;
    prev_idx   = 0;
    next_idx   = 0;
    for (int slot = 0; slot <= 10; slot++) begin
      @(negedge clk);
      compare_value("resp_valid_o", 32'(prev_valid), 32'(resp_valid));
      // The last accepted result stays on the outputs through the gaps.
      if (next_idx > 0) begin
        compare_value("result_o", vectors[prev_idx].result, result.raw);
        compare_value("fflags_o", 32'(vectors[prev_idx].flags), 32'(fflags));
      end
      prev_valid = 1'b0;
      req_valid  = 1'b0;
      if (slot < 10) begin
        // Gap slots present the next operands without a request.
        op_a.raw      = vectors[next_idx].a;
        op_b.raw      = vectors[next_idx].b;
        rounding_mode = vectors[next_idx].mode;
        if (burst[9 - slot]) begin
          req_valid     = 1'b1;
          prev_valid    = 1'b1;
          prev_idx      = next_idx;
          next_idx++;
        end
      end
    end
    report_test("timing", test_start);

    test_start = errors;
    for (int i = 0; i < num_vectors; i++) begin
      run_op(vectors[i].a, vectors[i].b, vectors[i].mode, res1, flg1);
      compare_value("result_o", vectors[i].result, res1);
      compare_value("fflags_o", 32'(vectors[i].flags), flg1);
    end
    report_test("directed table", test_start);

    // Every other pair gets close exponents so that alignment and cancellation occur.
    test_start = errors;
    for (int i = 0; i < 20; i++) begin
      x = $random(seed);
      y = $random(seed);
      if (i % 2 == 1) begin
        y[30:23] = x[30:23] - 8'(i % 5);
      end
      for (int m = 0; m < 5; m++) begin
        run_op(x, y, mode_of(m), res1, flg1);
        run_op(y, x, mode_of(m), res2, flg2);
        compare_value("result_o", res1, res2);
        compare_value("fflags_o", flg1, flg2);
      end
    end
    report_test("commutativity", test_start);

    test_start = errors;
    for (int i = 0; i < 10; i++) begin
      x = make_finite($random(seed));
      for (int m = 0; m < 5; m++) begin
        run_op(x, x ^ 32'h80000000, mode_of(m), res1, flg1);
        if (mode_of(m) == fpu_op_pkg::RoundTowardNegative) begin
          compare_value("result_o", 32'h80000000, res1);
        end else begin
          compare_value("result_o", 32'h00000000, res1);
        end
        compare_value("fflags_o", 32'h0, flg1);
      end
    end
    report_test("cancellation sign", test_start);

    test_start = errors;
    for (int i = 0; i < 10; i++) begin
      x = make_finite($random(seed));
      for (int m = 0; m < 5; m++) begin
        run_op(x, {i[0], 31'd0}, mode_of(m), res1, flg1);
        compare_value("result_o", x, res1);
        compare_value("fflags_o", 32'h0, flg1);
      end
      // A quiet NaN with a random sign and payload.
      y = $random(seed) | 32'h7fc00000;
      run_op({i[0], 31'd0}, y, mode_of(i % 5), res1, flg1);
      compare_value("result_o", 32'h7fc00000, res1);
      compare_value("fflags_o", 32'h0, flg1);
    end
    report_test("identity", test_start);

    $display("tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: tb.f
+incdir+common
+incdir+tb
common/fpu_format_pkg.sv
common/fpu_op_pkg.sv
rtl/fpu_normalize.sv
rtl/fpu_unpack.sv
fpu_add/fpu_right_shift.sv
fpu_add/fpu_add.sv
rtl/fpu_round_pack.sv
rtl/fpu_add_top.sv
tb/tb_fpu_add.sv

// File: run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log.
set -e

cd "$(dirname "$0")"

verilator --binary --assert --top-module tb_fpu_add -f tb.f -o tb_fpu_add

./obj_dir/tb_fpu_add | tee sim.log

if grep -q "Test failed" sim.log; then
  echo "Simulation FAILED, see sim.log"
  exit 1
fi

echo "Simulation passed"
